// File: project.f
+incdir+include
hw/mult_pkg.sv
hw/mult_issue_queue.sv
hw/mult_operand_prep.sv
hw/mult_stage.sv
hw/mult_pipeline.sv
hw/mult_unit.sv
tests/mult_unit_tb.sv

// File: tests/mult_unit_tb.sv
`include "mult_settings.svh"

module mult_unit_tb;
    import mult_pkg::*;

    localparam int STREAM_OPS = 200;
    localparam int FULL_OPS = 60;
    localparam int NUM_OPS = 100 + 1 + 2 * STREAM_OPS + FULL_OPS;
    localparam int TIMEOUT_CYCLES = (NUM_OPS + 20) * (`MULT_STAGES + 4);
    localparam int DRAIN_CYCLES = 4 * (`MULT_STAGES + 4);  // queue plus pipe empty well within this

    logic          clock;
    logic          reset;
    logic          issue_valid;
    issue_packet_t issue_pack;
    logic          issue_ready;
    logic          stall;
    fu_packet_t    fu_pack;
    logic          data_ready;

    integer     seed;
    int         cycles;
    int         error_count;
    int         check_count;
    int         issued;
    int         accept_cycle;
    int         stall_mode;  // 0 none, 1 random third, 2 long blocks
    logic       saw_not_ready;
    tag_t       next_tag;
    fu_packet_t exp_q[$];
    fu_packet_t expected;
    fu_packet_t held_pack;
    logic       held_valid;

    mult_func_t stream_func [STREAM_OPS];
    data_t      stream_a    [STREAM_OPS];
    data_t      stream_b    [STREAM_OPS];

    mult_unit DUT (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_pack  (issue_pack),
        .issue_ready (issue_ready),
        .stall       (stall),
        .fu_pack     (fu_pack),
        .data_ready  (data_ready)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) cycles <= cycles + 1;

    initial begin
        while (cycles < TIMEOUT_CYCLES) @(posedge clock);
        $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d, checks: %0d, issued: %0d", error_count + 1, check_count, issued);
        $display("Testbench failed");
        $finish;
    end

    // func picks the low or high word of the full 64-bit product
    function automatic data_t mult_ref(input mult_func_t func, input data_t a, input data_t b);
        longint prod;
        case (func)
            FUNC_MUL, FUNC_MULH: prod = longint'($signed(a)) * longint'($signed(b));
            FUNC_MULHSU:         prod = longint'($signed(a)) * longint'({32'b0, b});
            default:             prod = longint'({32'b0, a}) * longint'({32'b0, b});
        endcase
        return (func == FUNC_MUL) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic check_result(input string name, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        check_count++;
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // result bus back-pressure changes just after the edge
    always @(posedge clock) begin
        #1;
        case (stall_mode)
            1:       stall = (($unsigned($random(seed)) % 3) == 0);
            2:       stall = ((cycles % 40) < 30);
            default: stall = 1'b0;
        endcase
    end

    // scoreboard samples at the falling edge where outputs are settled
    always @(negedge clock) begin
        if (reset) begin
            held_valid = 1'b0;
        end else begin
            if (!issue_ready) saw_not_ready = 1'b1;
            if (held_valid) begin  // output must not move while stalled
                check_flag("data_ready", data_ready, 1'b1);
                check_result("fu_pack.result", fu_pack.result, held_pack.result);
                check_tag("fu_pack.dest_tag", fu_pack.dest_tag, held_pack.dest_tag);
            end
            if (data_ready && !stall) begin
                held_valid = 1'b0;
                if (exp_q.size() == 0) begin
                    $display("Error: result with tag %h came out with nothing expected",
                             fu_pack.dest_tag);
                    error_count++;
                end else begin
                    expected = exp_q.pop_front();
                    check_result("fu_pack.result", fu_pack.result, expected.result);
                    check_tag("fu_pack.dest_tag", fu_pack.dest_tag, expected.dest_tag);
                end
            end else if (data_ready) begin
                held_valid = 1'b1;
                held_pack  = fu_pack;
            end else begin
                held_valid = 1'b0;
            end
        end
    end

    // offers one packet and keeps it up until the queue takes it
    task automatic issue_op(input mult_func_t func, input data_t a, input data_t b);
        logic accepted;
        accepted    = 1'b0;
        issue_valid = 1'b1;
        issue_pack  = '{func: func, rs1_value: a, rs2_value: b, dest_tag: next_tag};
        while (!accepted) begin
            @(negedge clock);
            if (issue_ready) begin
                accepted = 1'b1;
                exp_q.push_back('{result: mult_ref(func, a, b), dest_tag: next_tag});
                accept_cycle = cycles + 1;
                issued++;
            end
            @(posedge clock);
            #1;
        end
        next_tag = next_tag + 1'b1;
    endtask

    task automatic stop_issue();
        issue_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clock);
            waited++;
        end
        @(posedge clock);
        #1;
    endtask

    task automatic play_stream();
        for (int i = 0; i < STREAM_OPS; i++) begin
            issue_op(stream_func[i], stream_a[i], stream_b[i]);
        end
        stop_issue();
    endtask

    initial begin
        data_t corner [5];
        corner = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
        seed        = 53;
        cycles      = 0;
        error_count = 0;
        check_count = 0;
        issued      = 0;
        stall_mode  = 0;
        next_tag    = '0;
        held_valid  = 1'b0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_pack  = '0;
        stall       = 1'b0;

        @(posedge clock);
        repeat (7) begin
            @(negedge clock);
            check_flag("data_ready", data_ready, 1'b0);
            check_flag("issue_ready", issue_ready, 1'b1);
        end
        @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        check_flag("data_ready", data_ready, 1'b0);
        check_flag("issue_ready", issue_ready, 1'b1);
        @(posedge clock);
        #1;

        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issue_op(mult_func_t'(f), corner[i], corner[j]);
                end
            end
        end
        stop_issue();
        wait_drain();

        // single op into an idle unit
        issue_op(FUNC_MULHSU, 32'hDEAD_BEEF, 32'h1234_5678);
        stop_issue();
        do @(negedge clock); while (!data_ready);
        if (cycles - accept_cycle != `MULT_STAGES + 1) begin
            $display("Error: latency was %0d cycles instead of %0d",
                     cycles - accept_cycle, `MULT_STAGES + 1);
            error_count++;
        end
        wait_drain();

        for (int i = 0; i < STREAM_OPS; i++) begin
            stream_func[i] = mult_func_t'($unsigned($random(seed)) % 4);
            stream_a[i]    = $random(seed);
            stream_b[i]    = $random(seed);
        end
        play_stream();
        wait_drain();

        stall_mode = 1;
        play_stream();
        stall_mode = 0;
        wait_drain();

        saw_not_ready = 1'b0;
        stall_mode    = 2;
        for (int i = 0; i < FULL_OPS; i++) begin
            issue_op(mult_func_t'($unsigned($random(seed)) % 4), $random(seed), $random(seed));
        end
        stop_issue();
        stall_mode = 0;
        wait_drain();
        if (!saw_not_ready) begin
            $display("Error: issue_ready never went low while the unit was stalled");
            error_count++;
        end

        repeat (10) @(negedge clock);
        if (exp_q.size() != 0) begin
            $display("Error: %0d expected results never came out", exp_q.size());
            error_count++;
        end
        $display("errors: %0d, checks: %0d, issued: %0d", error_count, check_count, issued);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: hw/mult_unit.sv
module mult_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  mult_pkg::issue_packet_t issue_pack,
    output logic                    issue_ready,
    input  logic                    stall,
    output mult_pkg::fu_packet_t    fu_pack,
    output logic                    data_ready
);
    import mult_pkg::*;

    logic          head_valid;
    issue_packet_t head_pack;
    logic          take;

    mult_issue_queue u_queue (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_pack  (issue_pack),
        .issue_ready (issue_ready),
        .take        (take),
        .head_valid  (head_valid),
        .head_pack   (head_pack)
    );

    mult_pipeline u_pipeline (
        .clock      (clock),
        .reset      (reset),
        .stall      (stall),
        .head_valid (head_valid),
        .head_pack  (head_pack),
        .take       (take),
        .fu_pack    (fu_pack),
        .data_ready (data_ready)
    );

endmodule

// File: hw/mult_pipeline.sv
`include "mult_settings.svh"

module mult_pipeline (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    head_valid,
    input  mult_pkg::issue_packet_t head_pack,
    output logic                    take,
    output mult_pkg::fu_packet_t    fu_pack,
    output logic                    data_ready
);
    import mult_pkg::*;

    localparam int STAGES = `MULT_STAGES;

    logic          in_valid;
    issue_packet_t in_pack;

    stage_info_t info      [0:STAGES];  // [0] feeds the first stage, [STAGES] is the output
    wide_t       sums      [0:STAGES];
    wide_t       mcands    [0:STAGES-1];
    wide_t       mpliers   [0:STAGES-1];

    wide_t final_sum;
    data_t result_word;

    // whole pipe moves as one, the result bus is the only source of back-pressure
    assign take = ~stall;

    // capture register in front of the multiplier stages
    always_ff @(posedge clock) begin
        if (reset) begin
            in_valid <= 1'b0;
        end else if (take) begin
            in_valid <= head_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            in_pack <= head_pack;
        end
    end

    mult_operand_prep u_prep (
        .func      (in_pack.func),
        .rs1_value (in_pack.rs1_value),
        .rs2_value (in_pack.rs2_value),
        .mcand     (mcands[0]),
        .mplier    (mpliers[0])
    );

    assign info[0] = '{valid: in_valid, func: in_pack.func, dest_tag: in_pack.dest_tag};
    assign sums[0] = '0;  // running sum starts empty

    for (genvar i = 0; i < STAGES; i++) begin : g_stage
        if (i < STAGES-1) begin : g_mid
            mult_stage u_stage (
                .clock       (clock),
                .reset       (reset),
                .advance     (take),
                .in_info     (info[i]),
                .prev_sum    (sums[i]),
                .mcand       (mcands[i]),
                .mplier      (mpliers[i]),
                .out_info    (info[i+1]),
                .product_sum (sums[i+1]),
                .next_mcand  (mcands[i+1]),
                .next_mplier (mpliers[i+1])
            );
        end else begin : g_last
            // shifted operands are spent after the last slice
            mult_stage u_stage (
                .clock       (clock),
                .reset       (reset),
                .advance     (take),
                .in_info     (info[i]),
                .prev_sum    (sums[i]),
                .mcand       (mcands[i]),
                .mplier      (mpliers[i]),
                .out_info    (info[i+1]),
                .product_sum (sums[i+1]),
                .next_mcand  (),
                .next_mplier ()
            );
        end
    end

    assign final_sum   = sums[STAGES];
    assign result_word = (info[STAGES].func == FUNC_MUL) ? final_sum[31:0] : final_sum[63:32];

    assign fu_pack    = '{result: result_word, dest_tag: info[STAGES].dest_tag};
    assign data_ready = info[STAGES].valid;

endmodule

// File: hw/mult_stage.sv
`include "mult_settings.svh"

module mult_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  advance,
    input  mult_pkg::stage_info_t in_info,
    input  mult_pkg::wide_t       prev_sum,
    input  mult_pkg::wide_t       mcand,
    input  mult_pkg::wide_t       mplier,
    output mult_pkg::stage_info_t out_info,
    output mult_pkg::wide_t       product_sum,
    output mult_pkg::wide_t       next_mcand,
    output mult_pkg::wide_t       next_mplier
);
    import mult_pkg::*;

    // multiplier bits consumed per stage
    localparam int SLICE = 64 / `MULT_STAGES;

    wide_t partial_product;
    wide_t shifted_mcand;
    wide_t shifted_mplier;

    assign partial_product = wide_t'(mplier[SLICE-1:0] * mcand);
    assign shifted_mplier  = mplier >> SLICE;  // next slice moves into the low bits
    assign shifted_mcand   = mcand << SLICE;   // weight follows the slice position

    // arithmetic and side info hold while the result bus stalls
    always_ff @(posedge clock) begin
        if (advance) begin
            product_sum       <= prev_sum + partial_product;
            next_mplier       <= shifted_mplier;
            next_mcand        <= shifted_mcand;
            out_info.func     <= in_info.func;
            out_info.dest_tag <= in_info.dest_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            out_info.valid <= 1'b0;
        end else if (advance) begin
            out_info.valid <= in_info.valid;
        end
    end

endmodule

// File: hw/mult_operand_prep.sv
module mult_operand_prep (
    input  mult_pkg::mult_func_t func,
    input  mult_pkg::data_t      rs1_value,
    input  mult_pkg::data_t      rs2_value,
    output mult_pkg::wide_t      mcand,
    output mult_pkg::wide_t      mplier
);
    import mult_pkg::*;

    wide_t rs1_signed;
    wide_t rs1_unsigned;
    wide_t rs2_signed;
    wide_t rs2_unsigned;

    assign rs1_signed   = {{32{rs1_value[31]}}, rs1_value};
    assign rs1_unsigned = {32'b0, rs1_value};
    assign rs2_signed   = {{32{rs2_value[31]}}, rs2_value};
    assign rs2_unsigned = {32'b0, rs2_value};

    // with both sides extended to 64 bits the low 64 product bits are exact
    always_comb begin
        case (func)
            FUNC_MUL, FUNC_MULH: begin
                mcand  = rs1_signed;
                mplier = rs2_signed;
            end
            FUNC_MULHSU: begin
                mcand  = rs1_signed;    // rs1 signed
                mplier = rs2_unsigned;  // rs2 unsigned
            end
            default: begin              // FUNC_MULHU and unused codes
                mcand  = rs1_unsigned;
                mplier = rs2_unsigned;
            end
        endcase
    end

endmodule

// File: hw/mult_issue_queue.sv
`include "mult_settings.svh"

module mult_issue_queue (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  mult_pkg::issue_packet_t issue_pack,
    output logic                    issue_ready,
    input  logic                    take,
    output logic                    head_valid,
    output mult_pkg::issue_packet_t head_pack
);
    import mult_pkg::*;

    localparam int PTR_BITS = $clog2(`MULT_QUEUE_DEPTH);

    issue_packet_t entries [`MULT_QUEUE_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;  // one extra bit so full is distinct from empty

    logic push;
    logic pop;

    assign issue_ready = (count != (PTR_BITS+1)'(`MULT_QUEUE_DEPTH));
    assign head_valid  = (count != '0);
    assign head_pack   = entries[rd_ptr];

    assign push = issue_valid && issue_ready;
    assign pop  = take && head_valid;

    // payload storage
    always_ff @(posedge clock) begin
        if (push) begin
            entries[wr_ptr] <= issue_pack;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // push and pop on the same edge leave the occupancy unchanged
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/mult_pkg.sv
`include "mult_settings.svh"

package mult_pkg;

    typedef logic [31:0] data_t;  // architectural register value
    typedef logic [63:0] wide_t;  // extended operand or running sum

    typedef logic [`MULT_TAG_BITS-1:0] tag_t;

    // funct3 field of the M-extension multiply group
    typedef logic [2:0] mult_func_t;

    localparam mult_func_t FUNC_MUL    = 3'd0;
    localparam mult_func_t FUNC_MULH   = 3'd1;
    localparam mult_func_t FUNC_MULHSU = 3'd2;
    localparam mult_func_t FUNC_MULHU  = 3'd3;

    // one multiply as it leaves the reservation station
    typedef struct packed {
        mult_func_t func;
        data_t      rs1_value;
        data_t      rs2_value;
        tag_t       dest_tag;
    } issue_packet_t;

    // control that rides next to the arithmetic in every stage
    typedef struct packed {
        logic       valid;
        mult_func_t func;
        tag_t       dest_tag;
    } stage_info_t;

    // handed to the result bus
    typedef struct packed {
        data_t result;
        tag_t  dest_tag;
    } fu_packet_t;

endpackage

// File: include/mult_settings.svh
`ifndef MULT_SETTINGS_SVH
`define MULT_SETTINGS_SVH

// number of multiplier stages, has to divide 64 evenly (2, 4 or 8)
`define MULT_STAGES 4

// issue queue entries, keep it a power of two
`define MULT_QUEUE_DEPTH 4

// destination physical register tag width
`define MULT_TAG_BITS 6

`endif
